// ==== project.f ====
src/ppu_pkg.sv
src/pixel_fifo_if.sv
src/tile_fetcher.sv
src/pixel_fifo.sv
src/framebuffer.sv
src/ppu_bg_top.sv
tests/fb_checker.sv
tests/tb_ppu_bg.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the background pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_ppu_bg \
  -f project.f \
  -o sim_ppu_bg

./obj_dir/sim_ppu_bg > sim.log 2>&1
cat sim.log

if grep -qF '** PASS **' sim.log; then
  echo "Simulation finished without errors"
else
  echo "Simulation reported errors, see sim.log"
  exit 1
fi

// ==== src/framebuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module framebuffer (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          flush,
  input  logic                          dot_en,
  input  logic [7:0]                    scx,
  input  logic [ppu_pkg::FB_ADDR_W-1:0] rd_addr,
  output logic                          frame_done,
  output ppu_pkg::gb_color_t            rd_data,
  pixel_fifo_if.framebuffer_side fifo_bus
);
  import ppu_pkg::*;

  // Pixels consumed in this line, 0..167
  logic [7:0] line_pix;
  logic [7:0] x_screen;
  logic [7:0] y_screen;
  // Address of pixel (0, y_screen)
  logic [FB_ADDR_W-1:0] row_base;
  logic [2:0] fine_q;

  logic [2:0] fine;
  logic visible;
  logic line_end;
  logic frame_end;
  logic [FB_ADDR_W-1:0] wr_addr;

  gb_color_t fb_mem [NUM_PIXELS];

  // Pop whenever drawing is enabled and a pixel is waiting
  assign fifo_bus.read_en = dot_en && !fifo_bus.empty;

  // Fine scroll taken live on the first pixel, held for the rest of the line
  assign fine = (line_pix == 8'd0) ? scx[2:0] : fine_q;
  assign visible = (line_pix >= {5'd0, fine}) && (x_screen < 8'(GB_SCREEN_WIDTH));
  assign line_end = line_pix == 8'(PIXELS_PER_LINE - 1);
  assign frame_end = visible && (x_screen == 8'(GB_SCREEN_WIDTH - 1)) &&
                     (y_screen == 8'(GB_SCREEN_HEIGHT - 1));
  assign wr_addr = row_base + FB_ADDR_W'(x_screen);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      line_pix <= '0;
      x_screen <= '0;
      y_screen <= '0;
      row_base <= '0;
      fine_q <= '0;
      frame_done <= 1'b0;
    end else if (flush) begin
      line_pix <= '0;
      x_screen <= '0;
      y_screen <= '0;
      row_base <= '0;
      fine_q <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= fifo_bus.read_en && frame_end;
      if (fifo_bus.read_en) begin
        if (line_pix == 8'd0) begin
          fine_q <= scx[2:0];
        end
        if (line_end) begin
          // Tail pixels are popped and dropped, never visible here
          line_pix <= '0;
          x_screen <= '0;
          if (y_screen == 8'(GB_SCREEN_HEIGHT - 1)) begin
            y_screen <= '0;
            row_base <= '0;
          end else begin
            y_screen <= y_screen + 8'd1;
            row_base <= row_base + FB_ADDR_W'(GB_SCREEN_WIDTH);
          end
        end else begin
          line_pix <= line_pix + 8'd1;
          if (visible) begin
            x_screen <= x_screen + 8'd1;
          end
        end
      end
    end
  end

  // Pixel store, write port
  always_ff @(posedge clk) begin
    if (fifo_bus.read_en && visible && !flush) begin
      fb_mem[wr_addr] <= fifo_bus.read_data;
    end
  end

  // Registered read port, one cycle latency
  always_ff @(posedge clk) begin
    rd_data <= fb_mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== src/pixel_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo (
  input logic clk,
  input logic reset,
  input logic flush,
  pixel_fifo_if.fifo_side fifo_bus
);
  import ppu_pkg::*;

  logic [PIX_FIFO_PTR_W-1:0] wr_ptr;
  logic [PIX_FIFO_PTR_W-1:0] rd_ptr;
  logic [PIX_FIFO_PTR_W-1:0] count;

  gb_color_t mem [PIX_FIFO_DEPTH];

  logic do_push;
  logic do_pop;

  // Extra pointer bit tells full from empty
  assign count = wr_ptr - rd_ptr;
  assign fifo_bus.empty = count == '0;
  assign fifo_bus.free_slots = PIX_FIFO_PTR_W'(PIX_FIFO_DEPTH) - count;

  // Head entry always visible to the writer
  assign fifo_bus.read_data = mem[rd_ptr[PIX_FIFO_PTR_W-2:0]];

  assign do_push = fifo_bus.push && (fifo_bus.free_slots != '0);
  assign do_pop = fifo_bus.read_en && !fifo_bus.empty;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr[PIX_FIFO_PTR_W-2:0]] <= fifo_bus.push_color;
    end
  end

endmodule

`default_nettype wire

// ==== src/pixel_fifo_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface pixel_fifo_if;
  import ppu_pkg::*;

  // Push side, fetcher to FIFO
  logic push;
  gb_color_t push_color;
  logic [PIX_FIFO_PTR_W-1:0] free_slots;

  // Pop side, FIFO to writer
  logic read_en;
  gb_color_t read_data;
  logic empty;

  modport fetcher_side (
    output push,
    output push_color,
    input  free_slots
  );

  modport fifo_side (
    input  push,
    input  push_color,
    output free_slots,
    input  read_en,
    output read_data,
    output empty
  );

  modport framebuffer_side (
    output read_en,
    input  read_data,
    input  empty
  );

endinterface

`default_nettype wire

// ==== src/ppu_bg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ppu_bg_top (
  input  logic        clk,
  input  logic        reset,
  input  logic        flush,
  input  logic        dot_en,
  input  logic [7:0]  scx,

  // Tile source, four-phase req/ack
  input  logic        tile_ack,
  input  logic [7:0]  tile_lo,
  input  logic [7:0]  tile_hi,
  output logic        tile_req,
  output logic [4:0]  tile_x,
  output logic [7:0]  tile_y,

  // Frame status and readback
  input  logic [14:0] rd_addr,
  output logic        frame_done,
  output logic [1:0]  rd_data
);

  // Pixel path between the three stages
  pixel_fifo_if fifo_bus ();

  tile_fetcher u_fetcher (
    .clk      (clk),
    .reset    (reset),
    .flush    (flush),
    .scx      (scx),
    .tile_ack (tile_ack),
    .tile_lo  (tile_lo),
    .tile_hi  (tile_hi),
    .tile_req (tile_req),
    .tile_x   (tile_x),
    .tile_y   (tile_y),
    .fifo_bus (fifo_bus.fetcher_side)
  );

  pixel_fifo u_fifo (
    .clk      (clk),
    .reset    (reset),
    .flush    (flush),
    .fifo_bus (fifo_bus.fifo_side)
  );

  // Writer is the only stage gated by dot_en
  framebuffer u_framebuffer (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .dot_en     (dot_en),
    .scx        (scx),
    .rd_addr    (rd_addr),
    .frame_done (frame_done),
    .rd_data    (rd_data),
    .fifo_bus   (fifo_bus.framebuffer_side)
  );

endmodule

`default_nettype wire

// ==== src/ppu_pkg.sv ====
`default_nettype none

package ppu_pkg;

  // Visible screen area
  localparam int GB_SCREEN_WIDTH = 160;
  localparam int GB_SCREEN_HEIGHT = 144;

  // Framebuffer holds one 2-bit word per visible pixel
  localparam int NUM_PIXELS = GB_SCREEN_WIDTH * GB_SCREEN_HEIGHT;
  localparam int FB_ADDR_W = 15;

  // 21 tiles cover 160 pixels plus up to 7 pixels of fine scroll
  localparam int TILES_PER_LINE = 21;
  localparam int PIXELS_PER_LINE = TILES_PER_LINE * 8;

  // Pixel FIFO sizing, pointers carry one extra wrap bit
  localparam int PIX_FIFO_DEPTH = 16;
  localparam int PIX_FIFO_PTR_W = 5;

  // Background color index 0..3
  typedef logic [1:0] gb_color_t;

endpackage

`default_nettype wire

// ==== src/tile_fetcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_fetcher (
  input  logic       clk,
  input  logic       reset,
  input  logic       flush,
  input  logic [7:0] scx,
  input  logic       tile_ack,
  input  logic [7:0] tile_lo,
  input  logic [7:0] tile_hi,
  output logic       tile_req,
  output logic [4:0] tile_x,
  output logic [7:0] tile_y,
  pixel_fifo_if.fetcher_side fifo_bus
);
  import ppu_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_WAIT_ACK_LOW,
    S_PUSH
  } fetch_state_t;

  fetch_state_t state;

  // Position within the frame
  logic [4:0] tile_cnt;
  logic [4:0] base_col;
  logic [7:0] line;
  logic [2:0] pix_cnt;

  // Captured bitplanes, MSB is the next pixel out
  logic [7:0] lo_sr;
  logic [7:0] hi_sr;

  logic room_for_tile;
  logic last_pix;
  logic last_tile;
  logic last_line;

  // Only start a tile when all eight pixels are guaranteed a slot
  assign room_for_tile = fifo_bus.free_slots >= PIX_FIFO_PTR_W'(8);
  assign last_pix = pix_cnt == 3'd7;
  assign last_tile = tile_cnt == 5'(TILES_PER_LINE - 1);
  assign last_line = line == 8'(GB_SCREEN_HEIGHT - 1);

  assign tile_req = state == S_REQ;
  assign tile_y = line;
  // Coarse column wraps mod 32
  assign tile_x = base_col + tile_cnt;

  assign fifo_bus.push = state == S_PUSH;
  assign fifo_bus.push_color = {hi_sr[7], lo_sr[7]};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= S_IDLE;
      tile_cnt <= '0;
      base_col <= '0;
      line <= '0;
      pix_cnt <= '0;
    end else if (flush) begin
      // Drop any request in flight and let the source release ack first
      state <= S_WAIT_ACK_LOW;
      tile_cnt <= '0;
      line <= '0;
      pix_cnt <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (room_for_tile && !tile_ack) begin
            // Coarse scroll sampled once per line
            if (tile_cnt == '0) begin
              base_col <= scx[7:3];
            end
            state <= S_REQ;
          end
        end

        S_REQ: begin
          if (tile_ack) begin
            pix_cnt <= '0;
            state <= S_PUSH;
          end
        end

        S_PUSH: begin
          pix_cnt <= pix_cnt + 3'd1;
          if (last_pix) begin
            if (last_tile) begin
              tile_cnt <= '0;
              line <= last_line ? 8'd0 : line + 8'd1;
            end else begin
              tile_cnt <= tile_cnt + 5'd1;
            end
            // Skip the wait state when the source has already released ack
            state <= tile_ack ? S_WAIT_ACK_LOW : S_IDLE;
          end
        end

        S_WAIT_ACK_LOW: begin
          if (!tile_ack) begin
            state <= S_IDLE;
          end
        end

        default: state <= S_IDLE;
      endcase
    end
  end

  // Bitplane shift register
  always_ff @(posedge clk) begin
    if (state == S_REQ && tile_ack) begin
      lo_sr <= tile_lo;
      hi_sr <= tile_hi;
    end else if (state == S_PUSH) begin
      lo_sr <= {lo_sr[6:0], 1'b0};
      hi_sr <= {hi_sr[6:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

// ==== tests/fb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_checker (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [7:0]                    scx,
  input  logic [7:0]                    key,
  input  logic                          tile_req,
  input  logic                          tile_ack,
  input  logic [4:0]                    tile_x,
  input  logic [7:0]                    tile_y,
  input  logic                          frame_done,
  input  logic                          rd_check,
  input  logic [ppu_pkg::FB_ADDR_W-1:0] rd_addr,
  input  ppu_pkg::gb_color_t            rd_data,
  output int                            pixel_errors,
  output int                            protocol_errors,
  output int                            frame_errors
);
  import ppu_pkg::*;

  string test_name = "reset";
  int pix_err_cnt = 0;
  int proto_err_cnt = 0;
  int frame_err_cnt = 0;
  int frames_seen = 0;
  int frames_at_start = 0;

  logic req_last = 1'b0;
  logic ack_last = 1'b0;
  logic first_pending = 1'b0;
  logic pend_valid = 1'b0;
  logic [FB_ADDR_W-1:0] pend_addr = '0;
  gb_color_t exp_color;

  assign pixel_errors = pix_err_cnt;
  assign protocol_errors = proto_err_cnt;
  assign frame_errors = frame_err_cnt;

  // Bitplane bytes of one tile row, also used by the tile source
  function automatic logic [15:0] tile_pattern(input logic [4:0] tx, input logic [7:0] ty,
                                               input logic [7:0] k);
    logic [7:0] lo;
    logic [7:0] hi;
    lo = ({3'b000, tx} * 8'd29) ^ (ty * 8'd7) ^ k;
    hi = ({3'b000, tx} + (ty * 8'd3)) ^ {k[4:0], k[7:5]} ^ 8'h96;
    return {hi, lo};
  endfunction

  // Screen pixel (x, y) shows background pixel (scx + x) mod 256 of line y
  function automatic gb_color_t expected_pixel(input logic [FB_ADDR_W-1:0] addr,
                                               input logic [7:0] sc, input logic [7:0] k);
    int px;
    int py;
    int bit_i;
    logic [7:0] bg;
    logic [15:0] pat;
    px = int'(addr) % GB_SCREEN_WIDTH;
    py = int'(addr) / GB_SCREEN_WIDTH;
    bg = 8'(int'(sc) + px);
    pat = tile_pattern(bg[7:3], 8'(py), k);
    // Leftmost pixel sits in bit 7
    bit_i = 7 - int'(bg[2:0]);
    return {pat[8 + bit_i], pat[bit_i]};
  endfunction

  task automatic start_test(input string name);
    test_name = name;
    frames_at_start = frames_seen;
  endtask

  task automatic finish_test();
    int pulses;
    pulses = frames_seen - frames_at_start;
    if (pulses != 1) begin
      frame_err_cnt++;
      $display("[FAIL] %s frame_done pulses: expected 1, actual %0d", test_name, pulses);
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      if (tile_req !== 1'b0 || frame_done !== 1'b0) begin
        proto_err_cnt++;
        $display("[FAIL] %s outputs in reset: expected tile_req 0 frame_done 0, actual %b %b",
                 test_name, tile_req, frame_done);
      end
      first_pending = 1'b1;
      req_last = 1'b0;
      ack_last = 1'b0;
      pend_valid = 1'b0;
    end else begin
      // A rising request must see ack low at the edge where it rose
      if (tile_req && !req_last && ack_last) begin
        proto_err_cnt++;
        $display("Handshake error in test %s: tile_req rose while tile_ack was still high",
                 test_name);
      end
      if (first_pending && tile_req) begin
        first_pending = 1'b0;
        if (tile_y !== 8'd0 || tile_x !== scx[7:3]) begin
          proto_err_cnt++;
          $display("[FAIL] %s first request: expected x %0d y 0, actual x %0d y %0d",
                   test_name, scx[7:3], tile_x, tile_y);
        end
      end
      req_last = tile_req;
      ack_last = tile_ack;
      if (frame_done) begin
        frames_seen++;
      end

      // Read data belongs to the address sampled one edge earlier
      if (pend_valid) begin
        exp_color = expected_pixel(pend_addr, scx, key);
        if (rd_data !== exp_color) begin
          pix_err_cnt++;
          $display("[FAIL] %s pixel x %0d y %0d: expected %0d, actual %0d", test_name,
                   int'(pend_addr) % GB_SCREEN_WIDTH, int'(pend_addr) / GB_SCREEN_WIDTH,
                   exp_color, rd_data);
        end
      end
      pend_valid = rd_check;
      pend_addr = rd_addr;
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_ppu_bg.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ppu_bg;
  import ppu_pkg::*;

  localparam int NUM_TESTS = 6;
  localparam int FRAME_TIMEOUT = NUM_PIXELS * 8;
  localparam int MIDFRAME_CYCLES = 12000;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * NUM_PIXELS * 12 + 10000;

  // Test table
  string test_names [NUM_TESTS] = '{"scx0_steady", "scx3_fine", "scx13_coarse",
                                    "scx250_wrap", "dot_en_random", "flush_midframe"};
  logic [7:0] test_scx [NUM_TESTS] = '{8'd0, 8'd3, 8'd13, 8'd250, 8'd37, 8'd94};
  logic [7:0] test_key [NUM_TESTS] = '{8'h3c, 8'ha5, 8'h71, 8'hd2, 8'h1e, 8'h88};
  logic test_dot_random [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
  logic test_flush_mid [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

  logic clk = 1'b0;
  logic reset;
  logic flush;
  logic dot_en = 1'b0;
  logic [7:0] scx;
  logic tile_ack = 1'b0;
  logic [7:0] tile_lo = 8'h00;
  logic [7:0] tile_hi = 8'h00;
  logic [FB_ADDR_W-1:0] rd_addr;
  logic tile_req;
  logic [4:0] tile_x;
  logic [7:0] tile_y;
  logic frame_done;
  logic [1:0] rd_data;

  // Stimulus control from the main sequence
  logic [7:0] key = 8'h00;
  logic dot_run = 1'b0;
  logic dot_mode = 1'b0;
  logic rd_check;
  integer seed = 22;

  typedef enum logic [1:0] {SRC_IDLE, SRC_DELAY, SRC_ACK} src_state_t;
  src_state_t src_state = SRC_IDLE;
  int src_delay = 0;
  logic [15:0] src_pat;

  int pixel_errors;
  int protocol_errors;
  int frame_errors;
  int timeout_errors = 0;
  int total_errors;

  always #2 clk = ~clk;

  ppu_bg_top DUT (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .dot_en     (dot_en),
    .scx        (scx),
    .tile_ack   (tile_ack),
    .tile_lo    (tile_lo),
    .tile_hi    (tile_hi),
    .tile_req   (tile_req),
    .tile_x     (tile_x),
    .tile_y     (tile_y),
    .rd_addr    (rd_addr),
    .frame_done (frame_done),
    .rd_data    (rd_data)
  );

  fb_checker u_checker (
    .clk             (clk),
    .reset           (reset),
    .scx             (scx),
    .key             (key),
    .tile_req        (tile_req),
    .tile_ack        (tile_ack),
    .tile_x          (tile_x),
    .tile_y          (tile_y),
    .frame_done      (frame_done),
    .rd_check        (rd_check),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .pixel_errors    (pixel_errors),
    .protocol_errors (protocol_errors),
    .frame_errors    (frame_errors)
  );

  // Tile source responder and dot_en drive
  always @(negedge clk) begin
    if (src_state == SRC_IDLE && tile_req) begin
      // Address and key are taken with the request
      src_pat = u_checker.tile_pattern(tile_x, tile_y, key);
      src_delay = $random(seed) & 3;
      src_state = SRC_DELAY;
    end
    if (src_state == SRC_DELAY) begin
      if (src_delay == 0) begin
        tile_hi = src_pat[15:8];
        tile_lo = src_pat[7:0];
        tile_ack = 1'b1;
        src_state = SRC_ACK;
      end else begin
        src_delay = src_delay - 1;
      end
    end else if (src_state == SRC_ACK && !tile_req) begin
      tile_ack = 1'b0;
      src_state = SRC_IDLE;
    end

    if (!dot_run) begin
      dot_en = 1'b0;
    end else if (dot_mode) begin
      dot_en = ($random(seed) & 1) == 1;
    end else begin
      dot_en = 1'b1;
    end
  end

  task automatic flush_dut(input int cycles);
    flush = 1'b1;
    repeat (cycles) @(negedge clk);
    flush = 1'b0;
  endtask

  task automatic wait_tile_request(input string where);
    bit seen;
    seen = 1'b0;
    for (int c = 0; c < 100; c++) begin
      @(negedge clk);
      if (tile_req) begin
        seen = 1'b1;
        break;
      end
    end
    if (!seen) begin
      timeout_errors++;
      $display("No tile_req appeared within 100 cycles %s", where);
    end
  endtask

  task automatic wait_frame_done(input string name, output bit ok);
    ok = 1'b0;
    for (int c = 0; c < FRAME_TIMEOUT; c++) begin
      @(negedge clk);
      if (frame_done) begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok) begin
      timeout_errors++;
      $display("Test %s timed out waiting for frame_done", name);
    end
  endtask

  // Walk every address while the checker compares one cycle later
  task automatic read_frame();
    for (int a = 0; a < NUM_PIXELS; a++) begin
      @(negedge clk);
      rd_addr = FB_ADDR_W'(a);
      rd_check = 1'b1;
    end
    @(negedge clk);
    rd_check = 1'b0;
    @(negedge clk);
  endtask

  task automatic run_test(input int idx);
    bit got_frame;
    u_checker.start_test(test_names[idx]);
    @(negedge clk);
    scx = test_scx[idx];
    dot_mode <= test_dot_random[idx];
    // A frame that is cut short draws with the inverted key first
    key <= test_flush_mid[idx] ? ~test_key[idx] : test_key[idx];
    flush_dut(2);
    dot_run <= 1'b1;
    if (test_flush_mid[idx]) begin
      repeat (MIDFRAME_CYCLES) @(negedge clk);
      // Abort with a tile request outstanding
      wait_tile_request("before the mid-frame flush");
      key <= test_key[idx];
      flush_dut(3);
    end
    wait_frame_done(test_names[idx], got_frame);
    // Writer holds during readback
    dot_run <= 1'b0;
    if (got_frame) begin
      read_frame();
    end
    u_checker.finish_test();
    $display("Test %s done", test_names[idx]);
  endtask

  initial begin
    reset = 1'b1;
    flush = 1'b0;
    scx = 8'h5d;
    rd_addr = '0;
    rd_check = 1'b0;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    wait_tile_request("after reset");

    for (int i = 0; i < NUM_TESTS; i++) begin
      run_test(i);
    end

    total_errors = pixel_errors + protocol_errors + frame_errors + timeout_errors;
    $display("Errors: pixel %0d, protocol %0d, frame count %0d, timeout %0d",
             pixel_errors, protocol_errors, frame_errors, timeout_errors);
    if (total_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Backstop against a stuck pipeline
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, simulation stopped", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire
